// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// datapath widths
	localparam int WORD_W = 8;
	localparam int INSTR_W = 8;
	localparam int PC_W = 3;
	localparam int REG_IDX_W = 2;
	localparam int NUM_REGS = 4;

	// data word in registers, alu and result
	typedef logic [WORD_W-1:0] word_t;

	// raw instruction as read from the program store
	typedef logic [INSTR_W-1:0] instr_t;

	// instruction address, wraps 7 -> 0
	typedef logic [PC_W-1:0] pc_t;

	// register number
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// opcode field, instruction bits 7:6
	typedef logic [1:0] opcode_t;

	localparam opcode_t OP_ALU = 2'b00;
	localparam opcode_t OP_LDI = 2'b01;
	localparam opcode_t OP_OUT = 2'b10;
	localparam opcode_t OP_BRZ = 2'b11;

	// alu function field, instruction bits 5:4
	typedef logic [1:0] alu_fn_t;

	localparam alu_fn_t FN_ADD = 2'b00;
	localparam alu_fn_t FN_SUB = 2'b01;
	localparam alu_fn_t FN_AND = 2'b10;
	localparam alu_fn_t FN_XOR = 2'b11;

	// decoded control for one instruction, 8 bits in total
	typedef struct packed {
		logic reg_write;
		logic result_load;
		logic sel_imm;
		logic pass_a;
		logic branch_zero;
		alu_fn_t alu_fn;
		logic spare;
	} ctrl_t;

endpackage

// ==== source/fetch_sequencer.sv ====
module fetch_sequencer #(
	parameter int unsigned STEP_DIV = 30
) (
	input logic clk,
	input logic arst_n,
	input logic branch_zero,
	input logic a_zero,
	input cpu_pkg::pc_t target,
	output logic step,
	output cpu_pkg::pc_t address
);

	// counter just wide enough for STEP_DIV-1
	localparam int CNT_W = (STEP_DIV > 2) ? $clog2(STEP_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(STEP_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic take_branch;
	cpu_pkg::pc_t pc_inc;
	cpu_pkg::pc_t pc_next;

	// step divider
	// counts down from STEP_DIV-1, step is high while it sits at zero
	// so the first step edge is clock STEP_DIV after reset release
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= CNT_LOAD;
		end else if (div_cnt == '0) begin
			// reload on the step edge
			div_cnt <= CNT_LOAD;
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	// one-clock pulse, decoded straight from the counter
	assign step = (div_cnt == '0);

	// next address
	// branch only when the decoder flags brz and reg a reads zero
	assign take_branch = branch_zero && a_zero;

	// natural 3-bit wrap, 7 -> 0
	assign pc_inc = address + 1'b1;

	assign pc_next = take_branch ? target : pc_inc;

	// program counter
	// moves only on step, holds in between
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			address <= '0;
		end else if (step) begin
			address <= pc_next;
		end
	end

endmodule

// ==== source/instr_decoder.sv ====
module instr_decoder (
	input cpu_pkg::instr_t instruction,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::word_t imm,
	output cpu_pkg::reg_idx_t ra,
	output cpu_pkg::reg_idx_t rb,
	output cpu_pkg::pc_t target
);

	// instruction fields
	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_fn_t fn_field;
	logic [3:0] imm_field;

	assign opcode = instruction[7:6];
	assign fn_field = instruction[5:4];
	assign imm_field = instruction[5:2];

	// register a in bits 1:0, register b in bits 3:2
	assign ra = instruction[1:0];
	assign rb = instruction[3:2];

	// branch target sits in bits 4:2
	assign target = instruction[4:2];

	// ldi immediate, zero extended to a full word
	assign imm = cpu_pkg::word_t'(imm_field);

	// control bits per opcode
	always_comb begin
		// everything off unless the opcode asks for it
		// spare bit stays low from here
		ctrl = '0;

		case (opcode)
			cpu_pkg::OP_ALU: begin
				// a <= a op b, also shown on result
				ctrl.reg_write = 1'b1;
				ctrl.result_load = 1'b1;
				ctrl.alu_fn = fn_field;
			end
			cpu_pkg::OP_LDI: begin
				// a <= imm, also shown on result
				ctrl.reg_write = 1'b1;
				ctrl.result_load = 1'b1;
				ctrl.sel_imm = 1'b1;
			end
			cpu_pkg::OP_OUT: begin
				// result <= a through the alu, no register write
				ctrl.result_load = 1'b1;
				ctrl.pass_a = 1'b1;
			end
			cpu_pkg::OP_BRZ: begin
				// only the sequencer reacts, result and regs hold
				ctrl.branch_zero = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// ==== source/regfile.sv ====
module regfile (
	input logic clk,
	input logic arst_n,
	input cpu_pkg::reg_idx_t ra,
	input cpu_pkg::reg_idx_t rb,
	input logic write_en,
	input cpu_pkg::word_t write_data,
	output cpu_pkg::word_t data_a,
	output cpu_pkg::word_t data_b
);

	// four general registers
	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	// write port
	// addressed by ra, the destination is always register a
	// write_en already carries the step strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// all registers start at zero
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[ra] <= write_data;
		end
	end

	// read ports
	// purely combinational, the new value shows after the write edge
	always_comb begin
		data_a = regs[ra];
	end

	always_comb begin
		data_b = regs[rb];
	end

endmodule

// ==== source/alu.sv ====
module alu (
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::alu_fn_t fn,
	input logic pass_a,
	output cpu_pkg::word_t y,
	output logic a_zero
);

	cpu_pkg::word_t op_out;

	// function select
	always_comb begin
		case (fn)
			// modulo 256, carry is dropped
			cpu_pkg::FN_ADD: op_out = a + b;
			// wraps below zero
			cpu_pkg::FN_SUB: op_out = a - b;
			cpu_pkg::FN_AND: op_out = a & b;
			cpu_pkg::FN_XOR: op_out = a ^ b;
			default: op_out = '0;
		endcase
	end

	// out instruction sends a straight through
	assign y = pass_a ? a : op_out;

	// zero test of register a for brz
	assign a_zero = (a == '0);

endmodule

// ==== source/processor.sv ====
module processor #(
	parameter int unsigned STEP_DIV = 30
) (
	input logic clk,
	input logic arst_n,
	input cpu_pkg::instr_t instruction,
	output cpu_pkg::pc_t address,
	output cpu_pkg::word_t result
);

	// decoder outputs
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::word_t imm;
	cpu_pkg::reg_idx_t ra;
	cpu_pkg::reg_idx_t rb;
	cpu_pkg::pc_t target;

	// register file reads
	cpu_pkg::word_t data_a;
	cpu_pkg::word_t data_b;

	// alu outputs
	cpu_pkg::word_t alu_out;
	logic a_zero;

	// step strobe from the divider
	logic step;

	// writeback path
	cpu_pkg::word_t write_data;
	logic reg_we;

	// address and step cadence
	fetch_sequencer #(
		.STEP_DIV(STEP_DIV)
	) i_fetch_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.branch_zero(ctrl.branch_zero),
		.a_zero(a_zero),
		.target(target),
		.step(step),
		.address(address)
	);

	// instruction decode, combinational
	instr_decoder i_instr_decoder (
		.instruction(instruction),
		.ctrl(ctrl),
		.imm(imm),
		.ra(ra),
		.rb(rb),
		.target(target)
	);

	// writes happen only on the step edge
	assign reg_we = step && ctrl.reg_write;

	regfile i_regfile (
		.clk(clk),
		.arst_n(arst_n),
		.ra(ra),
		.rb(rb),
		.write_en(reg_we),
		.write_data(write_data),
		.data_a(data_a),
		.data_b(data_b)
	);

	alu i_alu (
		.a(data_a),
		.b(data_b),
		.fn(ctrl.alu_fn),
		.pass_a(ctrl.pass_a),
		.y(alu_out),
		.a_zero(a_zero)
	);

	// ldi takes the immediate, alu and out take the alu output
	assign write_data = ctrl.sel_imm ? imm : alu_out;

	// result register
	// loads with the regfile on the same step edge
	// brz leaves it alone
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else if (step && ctrl.result_load) begin
			result <= write_data;
		end
	end

endmodule

// ==== verification/tb_processor.sv ====
module tb_processor;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned STEP_DIV = 4;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int STEP_TIMEOUT = 3 * STEP_DIV;
	localparam int NUM_RANDOM_PROGS = 4;
	localparam int RANDOM_STEPS = 40;

	// architectural state as the reference sees it
	typedef struct packed {
		cpu_pkg::word_t [3:0] regs;
		cpu_pkg::pc_t address;
		cpu_pkg::word_t result;
	} model_t;

	logic clk;
	logic arst_n;
	cpu_pkg::instr_t instruction;
	cpu_pkg::pc_t address;
	cpu_pkg::word_t result;

	// external program store
	cpu_pkg::instr_t program_mem [8];

	model_t model;
	int unsigned cycle_cnt;
	int unsigned next_step;
	int seed;

	processor #(
		.STEP_DIV(STEP_DIV)
	) i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.instruction(instruction),
		.address(address),
		.result(result)
	);

	// 8 ns clock, counts rising edges for the step schedule
	initial begin
		clk = 1'b0;
		cycle_cnt = 0;
		forever begin
			#4;
			clk = 1'b1;
			cycle_cnt++;
			#4;
			clk = 1'b0;
		end
	end

	// program store answers one clock after the address
	initial begin
		instruction = '0;
		forever begin
			@(posedge clk);
			instruction <= program_mem[address];
		end
	end

	// instruction encoders
	function automatic cpu_pkg::instr_t enc_ldi(cpu_pkg::reg_idx_t ra, logic [3:0] value);
		return {cpu_pkg::OP_LDI, value, ra};
	endfunction

	function automatic cpu_pkg::instr_t enc_alu(cpu_pkg::alu_fn_t fn, cpu_pkg::reg_idx_t rb,
			cpu_pkg::reg_idx_t ra);
		return {cpu_pkg::OP_ALU, fn, rb, ra};
	endfunction

	function automatic cpu_pkg::instr_t enc_out(cpu_pkg::reg_idx_t ra);
		return {cpu_pkg::OP_OUT, 4'b0000, ra};
	endfunction

	function automatic cpu_pkg::instr_t enc_brz(cpu_pkg::pc_t target, cpu_pkg::reg_idx_t ra);
		return {cpu_pkg::OP_BRZ, 1'b0, target, ra};
	endfunction

	// reference model, one instruction per call
	function automatic model_t next_state(model_t cur, cpu_pkg::instr_t ins);
		model_t nxt;
		cpu_pkg::word_t a_val;
		cpu_pkg::word_t b_val;
		cpu_pkg::word_t value;
		logic [1:0] ra_i;
		logic [1:0] rb_i;
		nxt = cur;
		ra_i = ins[1:0];
		rb_i = ins[3:2];
		a_val = cur.regs[ra_i];
		b_val = cur.regs[rb_i];
		value = '0;
		// default is fall through, 7 wraps to 0
		nxt.address = cur.address + 3'd1;
		case (ins[7:6])
			cpu_pkg::OP_ALU: begin
				case (ins[5:4])
					cpu_pkg::FN_ADD: value = a_val + b_val;
					cpu_pkg::FN_SUB: value = a_val - b_val;
					cpu_pkg::FN_AND: value = a_val & b_val;
					default: value = a_val ^ b_val;
				endcase
				nxt.regs[ra_i] = value;
				nxt.result = value;
			end
			cpu_pkg::OP_LDI: begin
				value = {4'b0000, ins[5:2]};
				nxt.regs[ra_i] = value;
				nxt.result = value;
			end
			cpu_pkg::OP_OUT: begin
				nxt.result = a_val;
			end
			default: begin
				// brz touches only the address
				if (a_val == '0) begin
					nxt.address = ins[4:2];
				end
			end
		endcase
		return nxt;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_pc(string name, cpu_pkg::pc_t actual, cpu_pkg::pc_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_word(string name, cpu_pkg::word_t actual, cpu_pkg::word_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t ns: %s is 0x%02h, expected 0x%02h",
				$time, name, actual, expected));
		end
	endtask

	// reset for RESET_CYCLES clocks, outputs must read zero throughout
	task automatic apply_reset();
		int unsigned held;
		@(posedge clk);
		arst_n <= 1'b0;
		held = 0;
		while (held < RESET_CYCLES) begin
			@(negedge clk);
			check_pc("address", address, '0);
			check_word("result", result, '0);
			@(posedge clk);
			held++;
		end
		arst_n <= 1'b1;
		@(negedge clk);
		model = '0;
		// first step edge is clock STEP_DIV after release
		next_step = cycle_cnt + STEP_DIV;
	endtask

	// wait out one step, outputs must hold until the step edge
	task automatic run_step();
		int waited;
		waited = 0;
		while (cycle_cnt < next_step) begin
			@(negedge clk);
			waited++;
			if (waited > STEP_TIMEOUT) begin
				abort_run($sformatf("timeout: no step edge came within %0d clocks",
					STEP_TIMEOUT));
			end else if (cycle_cnt < next_step) begin
				check_pc("address", address, model.address);
				check_word("result", result, model.result);
			end
		end
		model = next_state(model, program_mem[model.address]);
		check_pc("address", address, model.address);
		check_word("result", result, model.result);
		next_step += STEP_DIV;
	endtask

	task automatic run_program(int steps);
		for (int i = 0; i < steps; i++) begin
			run_step();
		end
	endtask

	task automatic load_random_program();
		for (int i = 0; i < 8; i++) begin
			program_mem[i] = cpu_pkg::instr_t'($random(seed));
		end
	endtask

	initial begin
		arst_n = 1'b1;
		seed = 52443;
		model = '0;
		next_step = 0;
		for (int i = 0; i < 8; i++) begin
			program_mem[i] = '0;
		end

		// loads, then add, sub below zero, and, xor
		$display("load and alu program");
		program_mem[0] = enc_ldi(2'd0, 4'd5);
		program_mem[1] = enc_ldi(2'd1, 4'd9);
		program_mem[2] = enc_ldi(2'd2, 4'd12);
		program_mem[3] = enc_ldi(2'd3, 4'd3);
		program_mem[4] = enc_alu(cpu_pkg::FN_ADD, 2'd1, 2'd0);
		program_mem[5] = enc_alu(cpu_pkg::FN_SUB, 2'd2, 2'd3);
		program_mem[6] = enc_alu(cpu_pkg::FN_AND, 2'd1, 2'd2);
		program_mem[7] = enc_alu(cpu_pkg::FN_XOR, 2'd3, 2'd1);
		apply_reset();
		// two passes, covers the 7 to 0 wrap
		run_program(16);

		// out shows all four registers in a mixed order
		$display("output program");
		program_mem[0] = enc_ldi(2'd0, 4'd7);
		program_mem[1] = enc_ldi(2'd1, 4'd10);
		program_mem[2] = enc_ldi(2'd2, 4'd15);
		program_mem[3] = enc_ldi(2'd3, 4'd1);
		program_mem[4] = enc_out(2'd1);
		program_mem[5] = enc_out(2'd3);
		program_mem[6] = enc_out(2'd0);
		program_mem[7] = enc_out(2'd2);
		apply_reset();
		run_program(8);

		// taken and not taken branches
		$display("branch program");
		program_mem[0] = enc_ldi(2'd1, 4'd3);
		program_mem[1] = enc_brz(3'd5, 2'd0);
		program_mem[2] = enc_ldi(2'd0, 4'd15);
		program_mem[3] = enc_out(2'd0);
		program_mem[4] = enc_ldi(2'd2, 4'd1);
		program_mem[5] = enc_brz(3'd0, 2'd1);
		program_mem[6] = enc_out(2'd1);
		program_mem[7] = enc_brz(3'd2, 2'd2);
		apply_reset();
		run_program(16);

		for (int p = 0; p < NUM_RANDOM_PROGS; p++) begin
			$display("random program %0d", p);
			load_random_program();
			apply_reset();
			run_program(RANDOM_STEPS);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== sim.f ====
source/cpu_pkg.sv
source/fetch_sequencer.sv
source/instr_decoder.sv
source/regfile.sv
source/alu.sv
source/processor.sv
verification/tb_processor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_processor
build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

rm -rf "$build_dir" "$log_file"

# rtl has no timescale of its own, give it the testbench units
verilator --binary --timing --timescale 1ns/1ps \
	--top-module "$top" \
	-Mdir "$build_dir" \
	-o "V$top" \
	-f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

# the log decides
if grep -q "TESTBENCH PASSED" "$log_file"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
